// ==== design/vgaSettings_settings.svh ====
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

// Video memory and framebuffer geometry
`define VGA_ADDRESS_BITS 13
`define VGA_ROW_BITS 7
`define VGA_COLUMN_BITS 4
`define VGA_MAX_SUB_PIXEL 3'd4

// Register widths that are not covered by a type
`define VGA_CONFIG_BITS 13
`define VGA_STATUS_BITS 5

// Upper 12 bus address bits that select this block
`define VGA_BLOCK_BASE 12'h800

`define VGA_REG_CONFIG 12'h000
`define VGA_REG_H_VISIBLE 12'h010
`define VGA_REG_H_FRONT 12'h014
`define VGA_REG_H_SYNC 12'h018
`define VGA_REG_H_WHOLE 12'h01C
`define VGA_REG_V_VISIBLE 12'h020
`define VGA_REG_V_FRONT 12'h024
`define VGA_REG_V_SYNC 12'h028
`define VGA_REG_V_WHOLE 12'h02C
`define VGA_REG_STATUS 12'h030

// 800x600 at 60 Hz, pixel stretch of 10 in both directions
`define VGA_DEFAULT_CONFIG 13'h0AA
`define VGA_DEFAULT_H_VISIBLE 11'd799
`define VGA_DEFAULT_H_FRONT 11'd839
`define VGA_DEFAULT_H_SYNC 11'd967
`define VGA_DEFAULT_H_WHOLE 11'd1055
`define VGA_DEFAULT_V_VISIBLE 10'd599
`define VGA_DEFAULT_V_FRONT 10'd600
`define VGA_DEFAULT_V_SYNC 10'd604
`define VGA_DEFAULT_V_WHOLE 10'd627

`define VGA_MODE_RAW 2'd0
`define VGA_MODE_TIGHT 2'd1

`endif

// ==== design/vgaPkg.sv ====
`default_nettype none

`include "vgaSettings_settings.svh"

package vgaPkg;

	// Peripheral bus
	typedef logic [23:0] busAddressT;
	typedef logic [31:0] busDataT;

	// Timing counters and their compares
	typedef logic [10:0] hCountT;
	typedef logic [9:0] vCountT;

	// Configuration fields
	typedef logic [3:0] pixelSizeT;
	typedef logic [1:0] drawModeT;

	// Pixel fetch path
	typedef logic [2:0] subPixelT;
	typedef logic [`VGA_ADDRESS_BITS-1:0] videoAddressT;
	typedef logic [17:0] linearPixelT;

	// Red in 1:0, green in 3:2, blue in 5:4
	typedef logic [5:0] pixelColourT;
	typedef logic [1:0] colourChannelT;

endpackage

`default_nettype wire

// ==== design/vgaConfigRegisters.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaSettings_settings.svh"

module vgaConfigRegisters (
	input wire logic vgaClk,
	input wire logic rst,
	input wire logic busWe,
	input wire logic busOe,
	input wire vgaPkg::busAddressT busAddress,
	input wire vgaPkg::busDataT busDataWrite,
	input wire logic [`VGA_STATUS_BITS-1:0] statusBits,
	output vgaPkg::busDataT busDataRead,
	output logic requestOutput,
	output vgaPkg::pixelSizeT horizontalPixelSize,
	output vgaPkg::pixelSizeT verticalPixelSize,
	output vgaPkg::drawModeT drawMode,
	output logic enableOutput,
	output logic hsyncIrqEnable,
	output logic vsyncIrqEnable,
	output vgaPkg::hCountT hVisible,
	output vgaPkg::hCountT hFront,
	output vgaPkg::hCountT hSync,
	output vgaPkg::hCountT hWhole,
	output vgaPkg::vCountT vVisible,
	output vgaPkg::vCountT vFront,
	output vgaPkg::vCountT vSync,
	output vgaPkg::vCountT vWhole
);

	logic blockSelected;
	logic [11:0] registerOffset;
	logic [`VGA_CONFIG_BITS-1:0] configReg;
	logic [`VGA_STATUS_BITS-1:0] statusReg;
	logic offsetMapped;
	vgaPkg::busDataT readWord;

	assign blockSelected = busAddress[23:12] == `VGA_BLOCK_BASE;
	assign registerOffset = busAddress[11:0];

	// Writable registers, only the declared width is kept
	always_ff @(posedge vgaClk) begin
		if (rst) begin
			configReg <= `VGA_DEFAULT_CONFIG;
			hVisible <= `VGA_DEFAULT_H_VISIBLE;
			hFront <= `VGA_DEFAULT_H_FRONT;
			hSync <= `VGA_DEFAULT_H_SYNC;
			hWhole <= `VGA_DEFAULT_H_WHOLE;
			vVisible <= `VGA_DEFAULT_V_VISIBLE;
			vFront <= `VGA_DEFAULT_V_FRONT;
			vSync <= `VGA_DEFAULT_V_SYNC;
			vWhole <= `VGA_DEFAULT_V_WHOLE;
		end else if (busWe && blockSelected) begin
			case (registerOffset)
				`VGA_REG_CONFIG: configReg <= busDataWrite[`VGA_CONFIG_BITS-1:0];
				`VGA_REG_H_VISIBLE: hVisible <= busDataWrite[10:0];
				`VGA_REG_H_FRONT: hFront <= busDataWrite[10:0];
				`VGA_REG_H_SYNC: hSync <= busDataWrite[10:0];
				`VGA_REG_H_WHOLE: hWhole <= busDataWrite[10:0];
				`VGA_REG_V_VISIBLE: vVisible <= busDataWrite[9:0];
				`VGA_REG_V_FRONT: vFront <= busDataWrite[9:0];
				`VGA_REG_V_SYNC: vSync <= busDataWrite[9:0];
				`VGA_REG_V_WHOLE: vWhole <= busDataWrite[9:0];
				default: ;
			endcase
		end
	end

	// Configuration fields
	assign horizontalPixelSize = configReg[3:0];
	assign verticalPixelSize = configReg[7:4];
	assign drawMode = configReg[9:8];
	assign enableOutput = configReg[10];
	assign hsyncIrqEnable = configReg[11];
	assign vsyncIrqEnable = configReg[12];

	// Status is sampled once so a read sees it one cycle late
	always_ff @(posedge vgaClk) begin
		if (rst) begin
			statusReg <= '0;
		end else begin
			statusReg <= statusBits;
		end
	end

	always_comb begin
		offsetMapped = 1'b1;
		readWord = '1;
		case (registerOffset)
			`VGA_REG_CONFIG: readWord = vgaPkg::busDataT'(configReg);
			`VGA_REG_H_VISIBLE: readWord = vgaPkg::busDataT'(hVisible);
			`VGA_REG_H_FRONT: readWord = vgaPkg::busDataT'(hFront);
			`VGA_REG_H_SYNC: readWord = vgaPkg::busDataT'(hSync);
			`VGA_REG_H_WHOLE: readWord = vgaPkg::busDataT'(hWhole);
			`VGA_REG_V_VISIBLE: readWord = vgaPkg::busDataT'(vVisible);
			`VGA_REG_V_FRONT: readWord = vgaPkg::busDataT'(vFront);
			`VGA_REG_V_SYNC: readWord = vgaPkg::busDataT'(vSync);
			`VGA_REG_V_WHOLE: readWord = vgaPkg::busDataT'(vWhole);
			`VGA_REG_STATUS: readWord = vgaPkg::busDataT'(statusReg);
			default: offsetMapped = 1'b0;
		endcase
	end

	assign requestOutput = busOe && blockSelected && offsetMapped;
	assign busDataRead = requestOutput ? readWord : '1;

endmodule

`default_nettype wire

// ==== design/vgaSyncGenerator.sv ====
`timescale 1ns/1ps
`default_nettype none

module vgaSyncGenerator (
	input wire logic vga_clk,
	input wire logic rst,
	input wire logic enableOutput,
	input wire logic hsyncIrqEnable,
	input wire logic vsyncIrqEnable,
	input wire vgaPkg::hCountT hVisible,
	input wire vgaPkg::hCountT hFront,
	input wire vgaPkg::hCountT hSync,
	input wire vgaPkg::hCountT hWhole,
	input wire vgaPkg::vCountT vVisible,
	input wire vgaPkg::vCountT vFront,
	input wire vgaPkg::vCountT vSync,
	input wire vgaPkg::vCountT vWhole,
	output logic hsync,
	output logic vsync,
	output logic inHorizontalVisible,
	output logic inVerticalVisible,
	output logic endHorizontalVisible,
	output logic [1:0] irq
);

	vgaPkg::hCountT hCount;
	vgaPkg::vCountT vCount;
	logic hEndFront;
	logic hEndSync;
	logic hEndLine;
	logic vEndVisible;
	logic vEndFront;
	logic vEndSync;
	logic vEndFrame;
	logic lastHsync;
	logic lastVsync;

	assign endHorizontalVisible = hCount == hVisible;
	assign hEndFront = hCount == hFront;
	assign hEndSync = hCount == hSync;
	assign hEndLine = hCount == hWhole;

	assign vEndVisible = vCount == vVisible;
	assign vEndFront = vCount == vFront;
	assign vEndSync = vCount == vSync;
	assign vEndFrame = vCount == vWhole;

	always_ff @(posedge vga_clk) begin
		if (rst || !enableOutput) begin
			hCount <= '0;
			inHorizontalVisible <= 1'b1;
			hsync <= 1'b1;
		end else begin
			hCount <= hEndLine ? '0 : hCount + 1'b1;
			if (endHorizontalVisible) begin
				inHorizontalVisible <= 1'b0;
			end else if (hEndLine) begin
				inHorizontalVisible <= 1'b1;
			end
			// Sync pulse spans front porch end to sync end
			if (hEndFront) begin
				hsync <= 1'b0;
			end else if (hEndSync) begin
				hsync <= 1'b1;
			end
		end
	end

	// Vertical events step once per line
	always_ff @(posedge vga_clk) begin
		if (rst || !enableOutput) begin
			vCount <= '0;
			inVerticalVisible <= 1'b1;
			vsync <= 1'b1;
		end else if (hEndLine) begin
			vCount <= vEndFrame ? '0 : vCount + 1'b1;
			if (vEndVisible) begin
				inVerticalVisible <= 1'b0;
			end else if (vEndFrame) begin
				inVerticalVisible <= 1'b1;
			end
			if (vEndFront) begin
				vsync <= 1'b0;
			end else if (vEndSync) begin
				vsync <= 1'b1;
			end
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			lastHsync <= 1'b1;
			lastVsync <= 1'b1;
		end else begin
			lastHsync <= hsync;
			lastVsync <= vsync;
		end
	end

	// High for the first low cycle of each sync pulse
	assign irq = {vsyncIrqEnable && lastVsync && !vsync, hsyncIrqEnable && lastHsync && !hsync};

endmodule

`default_nettype wire

// ==== design/vgaPixelAddresser.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaSettings_settings.svh"

module vgaPixelAddresser (
	input wire logic vga_clk,
	input wire logic rst,
	input wire logic enableOutput,
	input wire vgaPkg::drawModeT drawMode,
	input wire vgaPkg::pixelSizeT horizontalPixelSize,
	input wire vgaPkg::pixelSizeT verticalPixelSize,
	input wire logic inHorizontalVisible,
	input wire logic inVerticalVisible,
	input wire logic endHorizontalVisible,
	output logic fetchData,
	output vgaPkg::videoAddressT videoAddress,
	output vgaPkg::subPixelT subPixel
);

	vgaPkg::pixelSizeT hStretch;
	vgaPkg::pixelSizeT hStretchNext;
	vgaPkg::pixelSizeT hStretchIncrement;
	vgaPkg::pixelSizeT vStretch;
	vgaPkg::pixelSizeT vStretchNext;
	vgaPkg::pixelSizeT vStretchIncrement;
	vgaPkg::subPixelT subPixelCount;
	vgaPkg::subPixelT subPixelNext;
	vgaPkg::hCountT column;
	vgaPkg::hCountT columnNext;
	vgaPkg::hCountT columnIncrement;
	vgaPkg::vCountT row;
	vgaPkg::vCountT rowNext;
	vgaPkg::linearPixelT rowBase;
	vgaPkg::linearPixelT rowBaseNext;
	vgaPkg::linearPixelT linearPixel;
	vgaPkg::linearPixelT linearPixelNext;

	assign hStretchIncrement = hStretch + 4'd1;
	assign vStretchIncrement = vStretch + 4'd1;
	assign columnIncrement = column + 1'b1;

	always_comb begin
		hStretchNext = hStretch;
		vStretchNext = vStretch;
		subPixelNext = subPixelCount;
		columnNext = column;
		rowNext = row;
		rowBaseNext = rowBase;
		if (!enableOutput || !inVerticalVisible) begin
			hStretchNext = '0;
			vStretchNext = '0;
			subPixelNext = '0;
			columnNext = '0;
			rowNext = '0;
			rowBaseNext = '0;
		end else if (!inHorizontalVisible || endHorizontalVisible) begin
			// Line done, so park on the first word of the next line
			hStretchNext = '0;
			subPixelNext = '0;
			columnNext = '0;
			if (endHorizontalVisible) begin
				if (vStretchIncrement == verticalPixelSize) begin
					vStretchNext = '0;
					rowNext = row + 1'b1;
					rowBaseNext = rowBase + vgaPkg::linearPixelT'(columnIncrement);
				end else begin
					vStretchNext = vStretchIncrement;
				end
			end
		end else if (hStretchIncrement == horizontalPixelSize) begin
			hStretchNext = '0;
			if (subPixelCount == `VGA_MAX_SUB_PIXEL) begin
				subPixelNext = '0;
				columnNext = columnIncrement;
			end else begin
				subPixelNext = subPixelCount + 3'd1;
			end
		end else begin
			hStretchNext = hStretchIncrement;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (rst) begin
			hStretch <= '0;
			vStretch <= '0;
			subPixelCount <= '0;
			subPixel <= '0;
			column <= '0;
			row <= '0;
			rowBase <= '0;
		end else begin
			hStretch <= hStretchNext;
			vStretch <= vStretchNext;
			subPixelCount <= subPixelNext;
			// Lines up with the word latched one cycle after the fetch
			subPixel <= subPixelCount;
			column <= columnNext;
			row <= rowNext;
			rowBase <= rowBaseNext;
		end
	end

	assign linearPixel = rowBase + vgaPkg::linearPixelT'(column);
	assign linearPixelNext = rowBaseNext + vgaPkg::linearPixelT'(columnNext);

	// Address comes from next state so data is back one cycle after the counters move
	always_comb begin
		case (drawMode)
			`VGA_MODE_TIGHT: begin
				videoAddress = {linearPixelNext[`VGA_ADDRESS_BITS-3:0], 2'b00};
				fetchData = linearPixelNext != linearPixel;
			end
			// Palette and sprite codes fall back to raw addressing
			default: begin
				videoAddress = {rowNext[`VGA_ROW_BITS-1:0], columnNext[`VGA_COLUMN_BITS-1:0], 2'b00};
				fetchData = (rowNext != row) || (columnNext != column);
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== design/vgaPixelOutput.sv ====
`timescale 1ns/1ps
`default_nettype none

module vgaPixelOutput (
	input wire logic vga_clk,
	input wire logic rst,
	input wire logic enableOutput,
	input wire logic fetchData,
	input wire vgaPkg::busDataT videoData,
	input wire vgaPkg::subPixelT subPixel,
	input wire logic inHorizontalVisible,
	input wire logic inVerticalVisible,
	output vgaPkg::colourChannelT red,
	output vgaPkg::colourChannelT green,
	output vgaPkg::colourChannelT blue
);

	logic loadPixel;
	logic onScreen;
	vgaPkg::busDataT pixelWord;
	vgaPkg::pixelColourT pixel;

	// Memory answers in the cycle after the fetch
	always_ff @(posedge vga_clk) begin
		if (rst || !enableOutput) begin
			loadPixel <= 1'b0;
		end else begin
			loadPixel <= fetchData;
		end
	end

	always_ff @(posedge vga_clk) begin
		if (loadPixel) begin
			pixelWord <= videoData;
		end
	end

	// Five 6-bit pixels per word, top two bits unused
	always_comb begin
		case (subPixel)
			3'd1: pixel = pixelWord[11:6];
			3'd2: pixel = pixelWord[17:12];
			3'd3: pixel = pixelWord[23:18];
			3'd4: pixel = pixelWord[29:24];
			default: pixel = pixelWord[5:0];
		endcase
	end

	assign onScreen = enableOutput && inHorizontalVisible && inVerticalVisible;

	assign red = onScreen ? pixel[1:0] : '0;
	assign green = onScreen ? pixel[3:2] : '0;
	assign blue = onScreen ? pixel[5:4] : '0;

endmodule

`default_nettype wire

// ==== design/vgaController.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaSettings_settings.svh"

module vgaController (
	input wire logic vga_clk,
	input wire logic rst,
	input wire logic busWe,
	input wire logic busOe,
	input wire vgaPkg::busAddressT busAddress,
	input wire vgaPkg::busDataT busDataWrite,
	output vgaPkg::busDataT busDataRead,
	output logic requestOutput,
	output logic fetchData,
	output vgaPkg::videoAddressT videoAddress,
	input wire vgaPkg::busDataT videoData,
	output vgaPkg::colourChannelT red,
	output vgaPkg::colourChannelT green,
	output vgaPkg::colourChannelT blue,
	output logic hsync,
	output logic vsync,
	output logic [1:0] irq
);

	vgaPkg::pixelSizeT horizontalPixelSize;
	vgaPkg::pixelSizeT verticalPixelSize;
	vgaPkg::drawModeT drawMode;
	logic enableOutput;
	logic hsyncIrqEnable;
	logic vsyncIrqEnable;
	vgaPkg::hCountT hVisible;
	vgaPkg::hCountT hFront;
	vgaPkg::hCountT hSync;
	vgaPkg::hCountT hWhole;
	vgaPkg::vCountT vVisible;
	vgaPkg::vCountT vFront;
	vgaPkg::vCountT vSync;
	vgaPkg::vCountT vWhole;
	logic inHorizontalVisible;
	logic inVerticalVisible;
	logic endHorizontalVisible;
	vgaPkg::subPixelT subPixel;
	logic [`VGA_STATUS_BITS-1:0] statusBits;

	// Sync levels reported as active high
	assign statusBits = {inVerticalVisible, inHorizontalVisible, !vsync, !hsync, enableOutput};

	vgaConfigRegisters configRegisters_inst (
		.vgaClk(vga_clk),
		.rst(rst),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busDataWrite(busDataWrite),
		.statusBits(statusBits),
		.busDataRead(busDataRead),
		.requestOutput(requestOutput),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize),
		.drawMode(drawMode),
		.enableOutput(enableOutput),
		.hsyncIrqEnable(hsyncIrqEnable),
		.vsyncIrqEnable(vsyncIrqEnable),
		.hVisible(hVisible),
		.hFront(hFront),
		.hSync(hSync),
		.hWhole(hWhole),
		.vVisible(vVisible),
		.vFront(vFront),
		.vSync(vSync),
		.vWhole(vWhole)
	);

	vgaSyncGenerator syncGenerator_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.enableOutput(enableOutput),
		.hsyncIrqEnable(hsyncIrqEnable),
		.vsyncIrqEnable(vsyncIrqEnable),
		.hVisible(hVisible),
		.hFront(hFront),
		.hSync(hSync),
		.hWhole(hWhole),
		.vVisible(vVisible),
		.vFront(vFront),
		.vSync(vSync),
		.vWhole(vWhole),
		.hsync(hsync),
		.vsync(vsync),
		.inHorizontalVisible(inHorizontalVisible),
		.inVerticalVisible(inVerticalVisible),
		.endHorizontalVisible(endHorizontalVisible),
		.irq(irq)
	);

	vgaPixelAddresser pixelAddresser_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.enableOutput(enableOutput),
		.drawMode(drawMode),
		.horizontalPixelSize(horizontalPixelSize),
		.verticalPixelSize(verticalPixelSize),
		.inHorizontalVisible(inHorizontalVisible),
		.inVerticalVisible(inVerticalVisible),
		.endHorizontalVisible(endHorizontalVisible),
		.fetchData(fetchData),
		.videoAddress(videoAddress),
		.subPixel(subPixel)
	);

	vgaPixelOutput pixelOutput_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.enableOutput(enableOutput),
		.fetchData(fetchData),
		.videoData(videoData),
		.subPixel(subPixel),
		.inHorizontalVisible(inHorizontalVisible),
		.inVerticalVisible(inVerticalVisible),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

// ==== bench/vgaControllerTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vgaSettings_settings.svh"

module vgaControllerTb;

	// Small display timing, a 20-cycle line and a 12-line frame
	localparam int testHVisible = 13;
	localparam int testHFront = 15;
	localparam int testHSync = 17;
	localparam int testHWhole = 19;
	localparam int testVVisible = 5;
	localparam int testVFront = 7;
	localparam int testVSync = 8;
	localparam int testVWhole = 11;
	localparam int lineCycles = testHWhole + 1;
	localparam int frameCycles = lineCycles * (testVWhole + 1);
	localparam int wordsPerLine = (testHVisible + 1 + 4) / 5;
	localparam int testCycles = 200 + 14 * frameCycles;

	logic vga_clk;
	logic rst;
	logic busWe;
	logic busOe;
	vgaPkg::busAddressT busAddress;
	vgaPkg::busDataT busDataWrite;
	vgaPkg::busDataT busDataRead;
	logic requestOutput;
	logic fetchData;
	vgaPkg::videoAddressT videoAddress;
	vgaPkg::busDataT videoData;
	vgaPkg::colourChannelT red;
	vgaPkg::colourChannelT green;
	vgaPkg::colourChannelT blue;
	logic hsync;
	logic vsync;
	logic [1:0] irq;

	logic fetchSeen;
	vgaPkg::videoAddressT addressSeen;
	int fetchCount [0:8191];

	vgaController vgaController_inst (
		.vga_clk(vga_clk),
		.rst(rst),
		.busWe(busWe),
		.busOe(busOe),
		.busAddress(busAddress),
		.busDataWrite(busDataWrite),
		.busDataRead(busDataRead),
		.requestOutput(requestOutput),
		.fetchData(fetchData),
		.videoAddress(videoAddress),
		.videoData(videoData),
		.red(red),
		.green(green),
		.blue(blue),
		.hsync(hsync),
		.vsync(vsync),
		.irq(irq)
	);

	initial begin
		vga_clk = 1'b0;
		forever #4 vga_clk = ~vga_clk;
	end

	// Pixel field made from every address bit
	function automatic vgaPkg::pixelColourT pixelOf(input vgaPkg::videoAddressT address);
		return address[7:2] ^ {address[12:8], address[1]} ^ {5'd0, address[0]};
	endfunction

	function automatic vgaPkg::busDataT memoryWord(input vgaPkg::videoAddressT address);
		vgaPkg::pixelColourT field;
		field = pixelOf(address);
		return {2'b00, field, field, field, field, field};
	endfunction

	// Memory answers one cycle after each fetch
	always @(negedge vga_clk) begin
		fetchSeen = fetchData;
		addressSeen = videoAddress;
	end

	always @(posedge vga_clk) begin
		#1;
		if (fetchSeen) begin
			videoData = memoryWord(addressSeen);
		end
	end

	initial begin
		#(testCycles * 16);
		failCheck("Timeout: the tests did not finish in time");
	end

	task automatic failCheck(input string what);
		$display("%s", what);
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkBusData(input string name, input vgaPkg::busDataT actual,
			input vgaPkg::busDataT expected);
		if (actual !== expected) begin
			failCheck($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic checkAddress(input string name, input vgaPkg::videoAddressT actual,
			input vgaPkg::videoAddressT expected);
		if (actual !== expected) begin
			failCheck($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic checkColour(input string name, input vgaPkg::colourChannelT actual,
			input vgaPkg::colourChannelT expected);
		if (actual !== expected) begin
			failCheck($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, actual, expected));
		end
	endtask

	task automatic checkLevel(input string name, input logic actual, input logic expected);
		if (actual !== expected) begin
			failCheck($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, name, actual, expected));
		end
	endtask

	task automatic checkCount(input string name, input int actual, input int expected);
		if (actual != expected) begin
			failCheck($sformatf("Mismatch at %0t: %s got %0d expected %0d",
				$time, name, actual, expected));
		end
	endtask

	task automatic writeRegister(input logic [11:0] offset, input vgaPkg::busDataT data);
		@(posedge vga_clk);
		#1;
		busWe = 1'b1;
		busAddress = {`VGA_BLOCK_BASE, offset};
		busDataWrite = data;
		@(posedge vga_clk);
		#1;
		busWe = 1'b0;
	endtask

	task automatic readRegister(input logic [11:0] offset, output vgaPkg::busDataT data,
			output logic mapped);
		@(posedge vga_clk);
		#1;
		busOe = 1'b1;
		busAddress = {`VGA_BLOCK_BASE, offset};
		#2;
		data = busDataRead;
		mapped = requestOutput;
		@(posedge vga_clk);
		#1;
		busOe = 1'b0;
	endtask

	task automatic expectRegister(input logic [11:0] offset, input vgaPkg::busDataT expected);
		vgaPkg::busDataT data;
		logic mapped;
		readRegister(offset, data, mapped);
		checkLevel($sformatf("requestOutput @%h", offset), mapped, 1'b1);
		checkBusData($sformatf("busDataRead @%h", offset), data, expected);
	endtask

	task automatic waitVsyncFall();
		logic prev;
		@(negedge vga_clk);
		prev = vsync;
		@(negedge vga_clk);
		while (!(prev && !vsync)) begin
			prev = vsync;
			@(negedge vga_clk);
		end
	endtask

	// Low width and period in cycles, starting at a falling edge
	task automatic measureSync(input bit vertical, output int lowWidth, output int period);
		logic prev;
		logic now;
		int count;
		@(negedge vga_clk);
		now = vertical ? vsync : hsync;
		do begin
			prev = now;
			@(negedge vga_clk);
			now = vertical ? vsync : hsync;
		end while (!(prev && !now));
		count = 1;
		lowWidth = 0;
		do begin
			prev = now;
			@(negedge vga_clk);
			now = vertical ? vsync : hsync;
			count++;
			if (!prev && now) begin
				lowWidth = count - 1;
			end
		end while (!(prev && !now));
		period = count - 1;
	endtask

	task automatic testRegisters();
		logic [11:0] offsets [9];
		vgaPkg::busDataT masks [9];
		vgaPkg::busDataT values [9];
		vgaPkg::busDataT data;
		logic mapped;
		offsets = '{`VGA_REG_CONFIG, `VGA_REG_H_VISIBLE, `VGA_REG_H_FRONT, `VGA_REG_H_SYNC,
			`VGA_REG_H_WHOLE, `VGA_REG_V_VISIBLE, `VGA_REG_V_FRONT, `VGA_REG_V_SYNC,
			`VGA_REG_V_WHOLE};
		masks = '{32'h1FFF, 32'h7FF, 32'h7FF, 32'h7FF, 32'h7FF,
			32'h3FF, 32'h3FF, 32'h3FF, 32'h3FF};
		expectRegister(`VGA_REG_CONFIG, 32'h0AA);
		expectRegister(`VGA_REG_H_VISIBLE, 32'd799);
		expectRegister(`VGA_REG_H_FRONT, 32'd839);
		expectRegister(`VGA_REG_H_SYNC, 32'd967);
		expectRegister(`VGA_REG_H_WHOLE, 32'd1055);
		expectRegister(`VGA_REG_V_VISIBLE, 32'd599);
		expectRegister(`VGA_REG_V_FRONT, 32'd600);
		expectRegister(`VGA_REG_V_SYNC, 32'd604);
		expectRegister(`VGA_REG_V_WHOLE, 32'd627);
		// Output disabled and both syncs idle after reset
		readRegister(`VGA_REG_STATUS, data, mapped);
		checkLevel("requestOutput status", mapped, 1'b1);
		checkBusData("status enable and sync bits", data & 32'h7, 32'h0);
		foreach (offsets[i]) begin
			values[i] = $urandom;
			writeRegister(offsets[i], values[i]);
		end
		foreach (offsets[i]) begin
			expectRegister(offsets[i], values[i] & masks[i]);
		end
		readRegister(12'h034, data, mapped);
		checkLevel("requestOutput unmapped", mapped, 1'b0);
		checkBusData("busDataRead unmapped", data, 32'hFFFF_FFFF);
	endtask

	task automatic testSyncTiming();
		int lowWidth;
		int period;
		vgaPkg::busDataT data;
		logic mapped;
		writeRegister(`VGA_REG_CONFIG, 32'h0);
		writeRegister(`VGA_REG_H_VISIBLE, testHVisible);
		writeRegister(`VGA_REG_H_FRONT, testHFront);
		writeRegister(`VGA_REG_H_SYNC, testHSync);
		writeRegister(`VGA_REG_H_WHOLE, testHWhole);
		writeRegister(`VGA_REG_V_VISIBLE, testVVisible);
		writeRegister(`VGA_REG_V_FRONT, testVFront);
		writeRegister(`VGA_REG_V_SYNC, testVSync);
		writeRegister(`VGA_REG_V_WHOLE, testVWhole);
		repeat (3 * lineCycles) begin
			@(negedge vga_clk);
			checkLevel("hsync disabled", hsync, 1'b1);
			checkLevel("vsync disabled", vsync, 1'b1);
			checkLevel("fetchData disabled", fetchData, 1'b0);
			checkColour("red disabled", red, 2'd0);
			checkColour("green disabled", green, 2'd0);
			checkColour("blue disabled", blue, 2'd0);
		end
		// Raw mode, stretch 1 in both directions
		writeRegister(`VGA_REG_CONFIG, 32'h411);
		// Status now reports output enabled
		readRegister(`VGA_REG_STATUS, data, mapped);
		checkLevel("requestOutput status", mapped, 1'b1);
		checkBusData("status enable bit", data & 32'h1, 32'h1);
		measureSync(1'b0, lowWidth, period);
		checkCount("hsync low width", lowWidth, testHSync - testHFront);
		checkCount("hsync period", period, lineCycles);
		measureSync(1'b1, lowWidth, period);
		checkCount("vsync low width", lowWidth, (testVSync - testVFront) * lineCycles);
		checkCount("vsync period", period, frameCycles);
	endtask

	task automatic watchIrq(input bit vertical);
		logic prev;
		int pulses;
		pulses = 0;
		@(negedge vga_clk);
		prev = vertical ? vsync : hsync;
		repeat (2 * frameCycles) begin
			@(negedge vga_clk);
			if (vertical) begin
				checkLevel("irq[1]", irq[1], prev && !vsync);
				checkLevel("irq[0]", irq[0], 1'b0);
				prev = vsync;
			end else begin
				checkLevel("irq[0]", irq[0], prev && !hsync);
				checkLevel("irq[1]", irq[1], 1'b0);
				prev = hsync;
			end
			pulses += vertical ? irq[1] : irq[0];
		end
		if (pulses == 0) begin
			failCheck("No interrupt pulse was seen while the interrupt was enabled");
		end
	endtask

	task automatic testInterrupts();
		writeRegister(`VGA_REG_CONFIG, 32'hC11);
		watchIrq(1'b0);
		writeRegister(`VGA_REG_CONFIG, 32'h1411);
		watchIrq(1'b1);
	endtask

	task automatic testRawAddresses();
		logic prev;
		int total;
		writeRegister(`VGA_REG_CONFIG, 32'h411);
		foreach (fetchCount[i]) begin
			fetchCount[i] = 0;
		end
		total = 0;
		waitVsyncFall();
		do begin
			if (fetchData) begin
				fetchCount[videoAddress]++;
				total++;
			end
			prev = vsync;
			@(negedge vga_clk);
		end while (!(prev && !vsync));
		for (int row = 0; row <= testVVisible; row++) begin
			for (int column = 0; column < wordsPerLine; column++) begin
				checkCount($sformatf("fetches of row %0d column %0d", row, column),
					fetchCount[row * 64 + column * 4], 1);
			end
		end
		// The last line also parks on the first word of the row below
		checkCount("fetches past last row", fetchCount[(testVVisible + 1) * 64], 1);
		checkCount("raw fetch total", total, wordsPerLine * (testVVisible + 1) + 1);
	endtask

	task automatic testTightAddresses();
		logic prev;
		int count;
		int zeroFetches;
		vgaPkg::videoAddressT expected;
		writeRegister(`VGA_REG_CONFIG, 32'h511);
		expected = 4;
		count = 0;
		zeroFetches = 0;
		waitVsyncFall();
		do begin
			if (fetchData) begin
				if (videoAddress == 0) begin
					// Word 0 is fetched once, after the last visible row
					checkCount("tight fetches before address 0", count,
						wordsPerLine * (testVVisible + 1));
					zeroFetches++;
				end else begin
					checkAddress("videoAddress tight", videoAddress, expected);
					expected = expected + 4;
					count++;
				end
			end
			prev = vsync;
			@(negedge vga_clk);
		end while (!(prev && !vsync));
		checkCount("tight fetch count", count, wordsPerLine * (testVVisible + 1));
		checkCount("tight fetches of address 0", zeroFetches, 1);
	endtask

	task automatic testColours();
		logic prev;
		int hPos;
		int vPos;
		int column;
		vgaPkg::pixelColourT expected;
		writeRegister(`VGA_REG_CONFIG, 32'h411);
		waitVsyncFall();
		waitVsyncFall();
		// First low vsync cycle starts the line after the front porch
		hPos = 0;
		vPos = testVFront + 1;
		do begin
			if (hPos <= testHVisible && vPos <= testVVisible) begin
				column = (hPos == 0) ? 0 : (hPos - 1) / 5;
				expected = pixelOf(vgaPkg::videoAddressT'(vPos * 64 + column * 4));
				checkColour("red", red, expected[1:0]);
				checkColour("green", green, expected[3:2]);
				checkColour("blue", blue, expected[5:4]);
			end else begin
				checkColour("red blank", red, 2'd0);
				checkColour("green blank", green, 2'd0);
				checkColour("blue blank", blue, 2'd0);
			end
			prev = vsync;
			@(negedge vga_clk);
			hPos++;
			if (hPos > testHWhole) begin
				hPos = 0;
				vPos = (vPos == testVWhole) ? 0 : vPos + 1;
			end
		end while (!(prev && !vsync));
	endtask

	initial begin
		void'($urandom(32'hf1aa_7d8a));
		rst = 1'b1;
		busWe = 1'b0;
		busOe = 1'b0;
		busAddress = '0;
		busDataWrite = '0;
		videoData = '0;
		repeat (3) @(posedge vga_clk);
		#1;
		rst = 1'b0;
		testRegisters();
		testSyncTiming();
		testInterrupts();
		testRawAddresses();
		testTightAddresses();
		testColours();
		$display("Done: no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vgaController.f ====
+incdir+design
design/vgaPkg.sv
design/vgaConfigRegisters.sv
design/vgaSyncGenerator.sv
design/vgaPixelAddresser.sv
design/vgaPixelOutput.sv
design/vgaController.sv
bench/vgaControllerTb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal -f vgaController.f \
	--top-module vgaControllerTb -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -q "Done: no errors" &&
echo "PASS" || { echo "FAIL"; exit 1; }
